/* Bender.yml */
package:
  name: dcache

sources:
  - common/dcache_pkg.sv
  - hdl/dcache_ctrl.sv
  - dcache_ways/dcache_ways.sv
  - hdl/dcache_bus.sv
  - hdl/dcache.sv
  - target: test
    files:
      - test/dcache_props.sv
      - test/dcache_tb.sv

/* common/dcache_pkg.sv */
// data cache shared definitions
`default_nettype none

package dcache_pkg;

   // cache geometry
   localparam int WORD_W = 32;
   localparam int SET_N  = 8;
   localparam int IDX_W  = 3;
   localparam int BLK_W  = 1;
   localparam int BYT_W  = 2;
   localparam int TAG_W  = 26;
   localparam int WAY_N  = 2;

   // hit count lands here at the end of a flush
   localparam logic [WORD_W-1:0] HITCOUNT_ADDR = 32'h3100;

   typedef logic [WORD_W-1:0] word_t;

   // tag | idx | blk | byt
   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] idx;
      logic [BLK_W-1:0] blk;
      logic [BYT_W-1:0] byt;
   } dcache_fields_t;

   typedef union packed {
      word_t          raw;
      dcache_fields_t f;
   } dcache_addr_u;

   // one stored block, 92 bits
   typedef struct packed {
      logic             valid;
      logic             dirty;
      logic [TAG_W-1:0] tag;
      word_t [1:0]      data;
   } dcache_frame_t;

   typedef struct packed {
      logic         ren;
      logic         wen;
      logic         halt;
      dcache_addr_u addr;
      word_t        store;
   } cpu_req_t;

   typedef struct packed {
      logic  dhit;
      word_t load;
      logic  flushed;
   } cpu_rsp_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } mem_req_t;

   typedef struct packed {
      logic  dwait;
      word_t load;
   } mem_rsp_t;

   // memory address and store source
   typedef enum logic [1:0] {
      SEL_FILL,
      SEL_VICTIM,
      SEL_FLUSH,
      SEL_HITCNT
   } bus_sel_e;

endpackage

`default_nettype wire

/* dcache_ways/dcache_ways.sv */
// data cache tag and data frames
`timescale 1ns/1ps
`default_nettype none

module dcache_ways
   import dcache_pkg::*;
(
   input  logic             CLK,
   input  logic             nRST,
   input  cpu_req_t         req,
   input  logic             install,
   input  word_t            fill_word,
   input  word_t            mem_load,
   input  logic             flush_way,
   input  logic [IDX_W-1:0] flush_set,
   output logic             hit,
   output word_t            load,
   output dcache_frame_t    victim,
   output logic             victim_dirty,
   output dcache_frame_t    flush_frame,
   output logic             flush_frame_dirty
);

   // tag and data storage
   logic [TAG_W-1:0] tags   [WAY_N][SET_N];
   word_t [1:0]      blocks [WAY_N][SET_N];
   // per frame status bits
   logic [SET_N-1:0] valid  [WAY_N];
   logic [SET_N-1:0] dirty  [WAY_N];
   // way to replace next, per set
   logic [SET_N-1:0] lru;

   logic [WAY_N-1:0] way_hit;
   logic             hit_way;
   logic             victim_way;
   logic [TAG_W-1:0] tag;
   logic [IDX_W-1:0] idx;
   logic [BLK_W-1:0] blk;

   function automatic dcache_frame_t frame_at(input logic way, input logic [IDX_W-1:0] set);
      dcache_frame_t fr;
      fr.valid = valid[way][set];
      fr.dirty = dirty[way][set];
      fr.tag   = tags[way][set];
      fr.data  = blocks[way][set];
      return fr;
   endfunction

   assign tag = req.addr.f.tag;
   assign idx = req.addr.f.idx;
   assign blk = req.addr.f.blk;

   // tag compare on both ways
   always_comb begin
      for (int w = 0; w < WAY_N; w++) begin
         way_hit[w] = valid[w][idx] && (tags[w][idx] == tag);
      end
   end

   assign hit        = (req.ren | req.wen) & (|way_hit);
   assign hit_way    = way_hit[1];
   assign load       = blocks[hit_way][idx][blk];
   assign victim_way = lru[idx];

   always_comb begin
      victim      = frame_at(victim_way, idx);
      flush_frame = frame_at(flush_way, flush_set);
   end

   assign victim_dirty      = victim.valid & victim.dirty;
   assign flush_frame_dirty = flush_frame.valid & flush_frame.dirty;

   // status and lru
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int w = 0; w < WAY_N; w++) begin
            valid[w] <= '0;
            dirty[w] <= '0;
         end
         lru <= '0;
      end else if (install) begin
         valid[victim_way][idx] <= 1'b1;
         dirty[victim_way][idx] <= 1'b0;
         lru[idx]               <= ~victim_way;
      end else if (hit) begin
         // other way becomes lru
         lru[idx] <= ~hit_way;
         if (req.wen) begin
            dirty[hit_way][idx] <= 1'b1;
         end
      end
   end

   // frame contents
   always_ff @(posedge CLK) begin
      if (install) begin
         tags[victim_way][idx] <= tag;
         // fill_word holds the requested word
         if (blk == 1'b0) begin
            blocks[victim_way][idx] <= {mem_load, fill_word};
         end else begin
            blocks[victim_way][idx] <= {fill_word, mem_load};
         end
      end else if (hit && req.wen) begin
         blocks[hit_way][idx][blk] <= req.store;
      end
   end

endmodule

`default_nettype wire

/* files.f */
common/dcache_pkg.sv
hdl/dcache_ctrl.sv
dcache_ways/dcache_ways.sv
hdl/dcache_bus.sv
hdl/dcache.sv
test/dcache_props.sv
test/dcache_tb.sv

/* hdl/dcache.sv */
// data cache top level
`timescale 1ns/1ps
`default_nettype none

module dcache
   import dcache_pkg::*;
(
   input  logic     CLK,
   input  logic     nRST,
   input  cpu_req_t req,
   output cpu_rsp_t rsp,
   output mem_req_t mem_req,
   input  mem_rsp_t mem_rsp
);

   logic             hit;
   logic             victim_dirty;
   logic             flush_frame_dirty;
   logic             fill_capture;
   logic             install;
   logic             word_ptr;
   logic             flush_way;
   logic [IDX_W-1:0] flush_set;
   logic             first_try;
   logic             mem_ren;
   logic             mem_wen;
   logic             flushed;
   logic             count_hit;
   bus_sel_e         sel;
   word_t            load;
   word_t            fill_word;
   dcache_frame_t    victim;
   dcache_frame_t    flush_frame;

   // only requests that never missed count
   assign count_hit = hit & first_try;

   assign rsp = '{dhit: hit, load: load, flushed: flushed};

   dcache_ctrl u_ctrl (
      .CLK               (CLK),
      .nRST              (nRST),
      .req               (req),
      .hit               (hit),
      .victim_dirty      (victim_dirty),
      .flush_frame_dirty (flush_frame_dirty),
      .dwait             (mem_rsp.dwait),
      .sel               (sel),
      .fill_capture      (fill_capture),
      .install           (install),
      .word_ptr          (word_ptr),
      .flush_way         (flush_way),
      .flush_set         (flush_set),
      .first_try         (first_try),
      .mem_ren           (mem_ren),
      .mem_wen           (mem_wen),
      .flushed           (flushed)
   );

   dcache_ways u_ways (
      .CLK               (CLK),
      .nRST              (nRST),
      .req               (req),
      .install           (install),
      .fill_word         (fill_word),
      .mem_load          (mem_rsp.load),
      .flush_way         (flush_way),
      .flush_set         (flush_set),
      .hit               (hit),
      .load              (load),
      .victim            (victim),
      .victim_dirty      (victim_dirty),
      .flush_frame       (flush_frame),
      .flush_frame_dirty (flush_frame_dirty)
   );

   dcache_bus u_bus (
      .CLK          (CLK),
      .nRST         (nRST),
      .req          (req),
      .sel          (sel),
      .word_ptr     (word_ptr),
      .fill_capture (fill_capture),
      .count_hit    (count_hit),
      .victim       (victim),
      .flush_frame  (flush_frame),
      .flush_set    (flush_set),
      .mem_ren      (mem_ren),
      .mem_wen      (mem_wen),
      .mem_rsp      (mem_rsp),
      .mem_req      (mem_req),
      .fill_word    (fill_word)
   );

endmodule

`default_nettype wire

/* hdl/dcache_bus.sv */
// data cache memory side
`timescale 1ns/1ps
`default_nettype none

module dcache_bus
   import dcache_pkg::*;
(
   input  logic             CLK,
   input  logic             nRST,
   input  cpu_req_t         req,
   input  bus_sel_e         sel,
   input  logic             word_ptr,
   input  logic             fill_capture,
   input  logic             count_hit,
   input  dcache_frame_t    victim,
   input  dcache_frame_t    flush_frame,
   input  logic [IDX_W-1:0] flush_set,
   input  logic             mem_ren,
   input  logic             mem_wen,
   input  mem_rsp_t         mem_rsp,
   output mem_req_t         mem_req,
   output word_t            fill_word
);

   dcache_addr_u addr;
   word_t        store;
   word_t        hit_cnt;

   // address built from fields, byte offset stays zero
   always_comb begin
      addr.raw = '0;
      store    = '0;
      case (sel)
         SEL_FILL: begin
            // requested word first, then its neighbour
            addr.f.tag = req.addr.f.tag;
            addr.f.idx = req.addr.f.idx;
            addr.f.blk = req.addr.f.blk ^ word_ptr;
         end
         SEL_VICTIM: begin
            addr.f.tag = victim.tag;
            addr.f.idx = req.addr.f.idx;
            addr.f.blk = word_ptr;
            store      = victim.data[word_ptr];
         end
         SEL_FLUSH: begin
            addr.f.tag = flush_frame.tag;
            addr.f.idx = flush_set;
            addr.f.blk = word_ptr;
            store      = flush_frame.data[word_ptr];
         end
         default: begin
            addr.raw = HITCOUNT_ADDR;
            store    = hit_cnt;
         end
      endcase
   end

   assign mem_req = '{ren: mem_ren, wen: mem_wen, addr: addr.raw, store: store};

   // first fill word
   always_ff @(posedge CLK) begin
      if (fill_capture) begin
         fill_word <= mem_rsp.load;
      end
   end

   // first try hit count
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         hit_cnt <= '0;
      end else if (count_hit) begin
         hit_cnt <= hit_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hdl/dcache_ctrl.sv */
// data cache control FSM
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
   import dcache_pkg::*;
(
   input  logic             CLK,
   input  logic             nRST,
   input  cpu_req_t         req,
   input  logic             hit,
   input  logic             victim_dirty,
   input  logic             flush_frame_dirty,
   input  logic             dwait,
   output bus_sel_e         sel,
   output logic             fill_capture,
   output logic             install,
   output logic             word_ptr,
   output logic             flush_way,
   output logic [IDX_W-1:0] flush_set,
   output logic             first_try,
   output logic             mem_ren,
   output logic             mem_wen,
   output logic             flushed
);

   // one state per memory word
   typedef enum logic [3:0] {
      IDLE,
      EVICT0,
      EVICT1,
      FILL0,
      FILL1,
      FLUSH_SCAN,
      FLUSH0,
      FLUSH1,
      HIT_STORE,
      DONE
   } state_e;

   state_e         state;
   state_e         next_state;
   // flush walk pointer {way, set}
   logic [IDX_W:0] flush_ptr;
   logic [IDX_W:0] next_ptr;
   logic           req_any;
   logic           ptr_last;

   assign req_any   = req.ren | req.wen;
   assign flush_way = flush_ptr[IDX_W];
   assign flush_set = flush_ptr[IDX_W-1:0];
   // way 1, set 7
   assign ptr_last  = &flush_ptr;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state     <= IDLE;
         flush_ptr <= '0;
         first_try <= 1'b1;
      end else begin
         state     <= next_state;
         flush_ptr <= next_ptr;
         // cleared by a miss, set again once the request completes
         if (state == IDLE && req_any && !hit) begin
            first_try <= 1'b0;
         end else if (hit) begin
            first_try <= 1'b1;
         end
      end
   end

   always_comb begin
      next_state   = state;
      next_ptr     = flush_ptr;
      sel          = SEL_FILL;
      word_ptr     = 1'b0;
      mem_ren      = 1'b0;
      mem_wen      = 1'b0;
      fill_capture = 1'b0;
      install      = 1'b0;
      flushed      = 1'b0;
      case (state)
         IDLE: begin
            if (req_any && !hit) begin
               // dirty victim goes back to memory first
               next_state = victim_dirty ? EVICT0 : FILL0;
            end else if (req.halt && !req_any) begin
               next_state = FLUSH_SCAN;
            end
         end
         EVICT0: begin
            sel     = SEL_VICTIM;
            mem_wen = 1'b1;
            if (!dwait) begin
               next_state = EVICT1;
            end
         end
         EVICT1: begin
            sel      = SEL_VICTIM;
            word_ptr = 1'b1;
            mem_wen  = 1'b1;
            if (!dwait) begin
               next_state = FILL0;
            end
         end
         FILL0: begin
            // requested word comes first
            mem_ren      = 1'b1;
            fill_capture = !dwait;
            if (!dwait) begin
               next_state = FILL1;
            end
         end
         FILL1: begin
            word_ptr = 1'b1;
            mem_ren  = 1'b1;
            install  = !dwait;
            if (!dwait) begin
               next_state = IDLE;
            end
         end
         FLUSH_SCAN: begin
            // clean or invalid frames skipped one per cycle
            if (flush_frame_dirty) begin
               next_state = FLUSH0;
            end else if (ptr_last) begin
               next_state = HIT_STORE;
            end else begin
               next_ptr = flush_ptr + 1'b1;
            end
         end
         FLUSH0: begin
            sel     = SEL_FLUSH;
            mem_wen = 1'b1;
            if (!dwait) begin
               next_state = FLUSH1;
            end
         end
         FLUSH1: begin
            sel      = SEL_FLUSH;
            word_ptr = 1'b1;
            mem_wen  = 1'b1;
            if (!dwait) begin
               next_ptr   = flush_ptr + 1'b1;
               next_state = ptr_last ? HIT_STORE : FLUSH_SCAN;
            end
         end
         HIT_STORE: begin
            sel     = SEL_HITCNT;
            mem_wen = 1'b1;
            if (!dwait) begin
               next_state = DONE;
            end
         end
         default: begin
            // held until reset
            flushed = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

/* test/dcache_props.sv */
// data cache bus properties
`timescale 1ns/1ps
`default_nettype none

module dcache_props
   import dcache_pkg::*;
(
   input logic     CLK,
   input logic     nRST,
   input cpu_rsp_t rsp,
   input mem_req_t mem_req,
   input mem_rsp_t mem_rsp
);

   // failed assertion count
   int fail_cnt = 0;

   // one direction per memory access
   a_rw_excl: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_req.ren && mem_req.wen))
   else begin
      fail_cnt++;
      $error("memory read and write requested together");
   end

   // sticky until reset
   a_flushed_hold: assert property (@(posedge CLK) disable iff (!nRST)
      rsp.flushed |=> rsp.flushed)
   else begin
      fail_cnt++;
      $error("flushed dropped before reset");
   end

   // request frozen while memory stalls
   a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
      (mem_req.ren || mem_req.wen) && mem_rsp.dwait |=> $stable(mem_req))
   else begin
      fail_cnt++;
      $error("memory request changed while dwait was high");
   end

endmodule

`default_nettype wire

/* test/dcache_tb.sv */
// data cache testbench
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
   import dcache_pkg::*;
();

   // cycles allowed for any single wait
   localparam int LIMIT = 200;

   logic     CLK;
   logic     nRST;
   cpu_req_t req;
   cpu_rsp_t rsp;
   mem_req_t mem_req;
   mem_rsp_t mem_rsp;

   // word memory keyed by byte address
   word_t    mem [word_t];
   word_t    rd_log [$];
   int       wr_count;
   int       wait_cnt;
   mem_req_t seen_req;

   // reference cache with the same geometry and lru rule
   logic        m_valid [2][8];
   logic        m_dirty [2][8];
   logic [25:0] m_tag   [2][8];
   word_t       m_data  [2][8][2];
   logic        m_lru   [8];
   int          m_hits;
   word_t       ref_mem [word_t];

   int errors;
   int checks;

   dcache dut (
      .CLK     (CLK),
      .nRST    (nRST),
      .req     (req),
      .rsp     (rsp),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   bind dcache dcache_props u_props (
      .CLK     (CLK),
      .nRST    (nRST),
      .rsp     (rsp),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   always #20 CLK = ~CLK;

   // untouched words depend on the whole address
   function automatic word_t fill_pattern(input word_t a);
      return a * 32'h9e37_79b1 + 32'h0f1e_2d3c;
   endfunction

   function automatic word_t mem_read(input word_t a);
      return mem.exists(a) ? mem[a] : fill_pattern(a);
   endfunction

   function automatic word_t ref_read(input word_t a);
      return ref_mem.exists(a) ? ref_mem[a] : fill_pattern(a);
   endfunction

   // tag | set | word | byte
   function automatic word_t make_addr(input logic [25:0] t, input logic [2:0] s,
                                       input logic b);
      return {t, s, b, 2'b00};
   endfunction

   // memory holds dwait high 2 cycles and then low for one
   always begin
      @(negedge CLK);
      seen_req = mem_req;
      @(posedge CLK);
      if (!nRST) begin
         wait_cnt = 0;
      end else if (seen_req.ren || seen_req.wen) begin
         if (!mem_rsp.dwait) begin
            // word completes at this edge
            if (seen_req.wen) begin
               mem[seen_req.addr] = seen_req.store;
               wr_count++;
            end else begin
               rd_log.push_back(seen_req.addr);
            end
            wait_cnt = 0;
         end else begin
            wait_cnt++;
         end
      end else begin
         wait_cnt = 0;
      end
      #1;
      mem_rsp.dwait = !((mem_req.ren || mem_req.wen) && wait_cnt == 2);
      mem_rsp.load  = mem_read(mem_req.addr);
   end

   task automatic check(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic abort_run(input string why);
      $display("timeout at %0t: %s", $time, why);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   task automatic test_done(input string name, input int err_before);
      $display("test %-24s %s", name, (errors == err_before) ? "ok" : "failed");
   endtask

   task automatic preload(input word_t a, input word_t d);
      mem[a]     = d;
      ref_mem[a] = d;
   endtask

   task automatic model_reset();
      for (int w = 0; w < 2; w++) begin
         for (int s = 0; s < 8; s++) begin
            m_valid[w][s] = 1'b0;
            m_dirty[w][s] = 1'b0;
         end
      end
      for (int s = 0; s < 8; s++) begin
         m_lru[s] = 1'b0;
      end
      m_hits = 0;
   endtask

   // predicted response with state updated as the cache would
   task automatic model_access(input logic wr, input word_t a, input word_t d,
                               output word_t exp_load, output logic exp_quick);
      logic [25:0] t;
      logic [2:0]  s;
      logic        b;
      int          w;
      word_t       base;
      t = a[31:6];
      s = a[5:3];
      b = a[2];
      w = -1;
      for (int i = 0; i < 2; i++) begin
         if (m_valid[i][s] && m_tag[i][s] == t) begin
            w = i;
         end
      end
      exp_quick = (w >= 0);
      if (w < 0) begin
         w = m_lru[s];
         // dirty victim goes back before the fill
         if (m_valid[w][s] && m_dirty[w][s]) begin
            base = {m_tag[w][s], s, 3'b000};
            ref_mem[base]     = m_data[w][s][0];
            ref_mem[base + 4] = m_data[w][s][1];
         end
         base = {t, s, 3'b000};
         m_valid[w][s]   = 1'b1;
         m_dirty[w][s]   = 1'b0;
         m_tag[w][s]     = t;
         m_data[w][s][0] = ref_read(base);
         m_data[w][s][1] = ref_read(base + 4);
      end else begin
         m_hits++;
      end
      // other way is replaced next
      m_lru[s] = (w == 0);
      exp_load = m_data[w][s][b];
      if (wr) begin
         m_data[w][s][b] = d;
         m_dirty[w][s]   = 1'b1;
      end
   endtask

   // way 0 first, sets 0 to 7
   task automatic model_flush();
      word_t base;
      for (int w = 0; w < 2; w++) begin
         for (int s = 0; s < 8; s++) begin
            if (m_valid[w][s] && m_dirty[w][s]) begin
               base = {m_tag[w][s], 3'(s), 3'b000};
               ref_mem[base]     = m_data[w][s][0];
               ref_mem[base + 4] = m_data[w][s][1];
            end
         end
      end
   endtask

   // one cpu request held until dhit
   task automatic cpu_access(input logic wr, input word_t a, input word_t d,
                             output word_t got, output logic quick);
      word_t exp_load;
      logic  exp_quick;
      int    cyc;
      model_access(wr, a, d, exp_load, exp_quick);
      req.ren   = !wr;
      req.wen   = wr;
      req.addr  = a;
      req.store = d;
      cyc = 0;
      @(negedge CLK);
      while (!rsp.dhit && cyc < LIMIT) begin
         cyc++;
         @(negedge CLK);
      end
      if (!rsp.dhit) begin
         abort_run($sformatf("no dhit for address %h within %0d cycles", a, LIMIT));
      end
      got   = rsp.load;
      quick = (cyc == 0);
      check("rsp.dhit first cycle", quick, exp_quick);
      if (!wr) begin
         check("rsp.load", got, exp_load);
      end
      @(posedge CLK);
      #2;
      req.ren = 1'b0;
      req.wen = 1'b0;
   endtask

   task automatic test_read_miss_hit();
      word_t a;
      word_t d0;
      word_t d1;
      word_t got;
      logic  quick;
      int    e0;
      e0 = errors;
      a  = make_addr(26'h040, 3'd2, 1'b1);
      d0 = $urandom();
      d1 = $urandom();
      preload(a, d0);
      preload(a ^ 32'h4, d1);
      rd_log.delete();
      cpu_access(1'b0, a, '0, got, quick);
      check("rsp.load", got, d0);
      check("rsp.dhit first cycle", quick, 1'b0);
      // two reads, both inside the block
      check("fill read count", rd_log.size(), 2);
      check("fill read addr", rd_log[0] & ~32'h7, a & ~32'h7);
      check("fill read addr", rd_log[1] & ~32'h7, a & ~32'h7);
      check("fill read word pair", rd_log[0] ^ rd_log[1], 32'h4);
      cpu_access(1'b0, a, '0, got, quick);
      check("rsp.load", got, d0);
      check("rsp.dhit first cycle", quick, 1'b1);
      cpu_access(1'b0, a ^ 32'h4, '0, got, quick);
      check("rsp.load", got, d1);
      check("rsp.dhit first cycle", quick, 1'b1);
      test_done("read miss then hit", e0);
   endtask

   task automatic test_write_hit();
      word_t a;
      word_t d;
      word_t got;
      logic  quick;
      int    w0;
      int    e0;
      e0 = errors;
      a  = make_addr(26'h040, 3'd2, 1'b1);
      d  = $urandom();
      w0 = wr_count;
      cpu_access(1'b1, a, d, got, quick);
      check("rsp.dhit first cycle", quick, 1'b1);
      cpu_access(1'b0, a, '0, got, quick);
      check("rsp.load", got, d);
      // write-back cache leaves memory alone
      check("mem write count", wr_count, w0);
      test_done("write hit", e0);
   endtask

   task automatic test_write_miss();
      word_t a;
      word_t d;
      word_t nb;
      word_t got;
      logic  quick;
      int    e0;
      e0 = errors;
      a  = make_addr(26'h051, 3'd5, 1'b0);
      nb = mem_read(a ^ 32'h4);
      d  = $urandom();
      cpu_access(1'b1, a, d, got, quick);
      check("rsp.dhit first cycle", quick, 1'b0);
      cpu_access(1'b0, a, '0, got, quick);
      check("rsp.load", got, d);
      cpu_access(1'b0, a ^ 32'h4, '0, got, quick);
      check("rsp.load", got, nb);
      test_done("write miss", e0);
   endtask

   task automatic test_lru_evict();
      word_t x;
      word_t y;
      word_t z;
      word_t dx0;
      word_t dx1;
      word_t got;
      logic  quick;
      int    w0;
      int    e0;
      e0  = errors;
      x   = make_addr(26'h061, 3'd6, 1'b0);
      y   = make_addr(26'h062, 3'd6, 1'b0);
      z   = make_addr(26'h063, 3'd6, 1'b0);
      dx0 = $urandom();
      dx1 = $urandom();
      // x dirty in one way, y clean in the other
      cpu_access(1'b1, x, dx0, got, quick);
      cpu_access(1'b1, x ^ 32'h4, dx1, got, quick);
      cpu_access(1'b0, y, '0, got, quick);
      w0 = wr_count;
      cpu_access(1'b0, z, '0, got, quick);
      check("rsp.dhit first cycle", quick, 1'b0);
      check("victim write count", wr_count - w0, 2);
      check($sformatf("mem[%h]", x), mem_read(x), dx0);
      check($sformatf("mem[%h]", x ^ 32'h4), mem_read(x ^ 32'h4), dx1);
      cpu_access(1'b0, x, '0, got, quick);
      check("rsp.load", got, dx0);
      check("rsp.dhit first cycle", quick, 1'b0);
      test_done("lru eviction", e0);
   endtask

   task automatic test_flush();
      word_t got;
      logic  quick;
      int    cyc;
      int    e0;
      e0 = errors;
      // spread dirty frames over several sets
      for (int i = 0; i < 6; i++) begin
         cpu_access(1'b1, make_addr(26'h070 + 26'(i), 3'(i), i[0]), $urandom(), got, quick);
      end
      req.halt = 1'b1;
      cyc = 0;
      @(negedge CLK);
      while (!rsp.flushed && cyc < LIMIT) begin
         cyc++;
         @(negedge CLK);
      end
      if (!rsp.flushed) begin
         abort_run("flushed did not rise after halt");
      end
      model_flush();
      foreach (ref_mem[k]) begin
         check($sformatf("mem[%h]", k), mem_read(k), ref_mem[k]);
      end
      check("mem[00003100]", mem_read(HITCOUNT_ADDR), m_hits);
      // flushed holds until reset
      repeat (4) begin
         @(negedge CLK);
         check("rsp.flushed", rsp.flushed, 1'b1);
      end
      test_done("halt flush", e0);
   endtask

   initial begin
      CLK           = 1'b0;
      nRST          = 1'b0;
      req           = '0;
      mem_rsp.dwait = 1'b1;
      mem_rsp.load  = '0;
      errors        = 0;
      checks        = 0;
      wr_count      = 0;
      wait_cnt      = 0;
      model_reset();
      void'($urandom(32'hc548));
      repeat (8) @(posedge CLK);
      #2;
      nRST = 1'b1;
      test_read_miss_hit();
      test_write_hit();
      test_write_miss();
      test_lru_evict();
      test_flush();
      errors += dut.u_props.fail_cnt;
      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
